//--- logic/valu_config.svh
`ifndef VALU_CONFIG_SVH
`define VALU_CONFIG_SVH

// operand and result word width
`define VALU_XLEN 64

`define VALU_BYTES 8     // bytes per word, for the pop count

// widest legal element, code 3 is 64 bits
`define VALU_SEW_MAX 3

`endif

//--- logic/valu_isa_pkg.sv
`default_nettype none

package valu_isa_pkg;

    // integer group, OPIVV funct6
    localparam logic [5:0] OP_VADD  = 6'b000000;
    localparam logic [5:0] OP_VSUB  = 6'b000010;
    localparam logic [5:0] OP_VRSUB = 6'b000011;
    localparam logic [5:0] OP_VMINU = 6'b000100;
    localparam logic [5:0] OP_VMIN  = 6'b000101;
    localparam logic [5:0] OP_VMAXU = 6'b000110;
    localparam logic [5:0] OP_VMAX  = 6'b000111;
    localparam logic [5:0] OP_VAND  = 6'b001001;
    localparam logic [5:0] OP_VOR   = 6'b001010;
    localparam logic [5:0] OP_VXOR  = 6'b001011;

    // mask group, OPMVV funct6
    localparam logic [5:0] OP_VMUNARY0 = 6'b010000;   // vcpop lives here
    localparam logic [5:0] OP_VMANDN   = 6'b011000;
    localparam logic [5:0] OP_VMAND    = 6'b011001;
    localparam logic [5:0] OP_VMOR     = 6'b011010;
    localparam logic [5:0] OP_VMXOR    = 6'b011011;
    localparam logic [5:0] OP_VMORN    = 6'b011100;
    localparam logic [5:0] OP_VMNAND   = 6'b011101;
    localparam logic [5:0] OP_VMNOR    = 6'b011110;
    localparam logic [5:0] OP_VMXNOR   = 6'b011111;

    localparam logic [4:0] VS1_VCPOP = 5'b10000;   // vs1 field picks vcpop

    typedef enum logic [2:0] {
        SEW_8  = 3'd0,
        SEW_16 = 3'd1,
        SEW_32 = 3'd2,
        SEW_64 = 3'd3
    } sew_e;

    // integer kinds first, mask kinds from OPK_MAND on
    typedef enum logic [4:0] {
        OPK_ILLEGAL, OPK_AND, OPK_OR, OPK_XOR,
        OPK_ADD, OPK_SUB, OPK_RSUB,
        OPK_MINU, OPK_MIN, OPK_MAXU, OPK_MAX,
        OPK_MAND, OPK_MNAND, OPK_MANDN, OPK_MXOR,
        OPK_MOR, OPK_MNOR, OPK_MORN, OPK_MXNOR,
        OPK_CPOP
    } op_kind_e;

endpackage

`default_nettype wire

//--- logic/valu_data_pkg.sv
`default_nettype none

`include "valu_config.svh"

package valu_data_pkg;

    // request as it comes from the issue stage
    typedef struct packed {
        logic [5:0]             opcode;
        logic                   is_mask;     // OPM group when set
        logic [4:0]             vs1_index;
        valu_isa_pkg::sew_e     sew;
        logic [`VALU_XLEN-1:0]  vs1;
        logic [`VALU_XLEN-1:0]  vs2;
    } valu_req_t;

    // decoded operation held for one cycle
    typedef struct packed {
        valu_isa_pkg::op_kind_e kind;
        valu_isa_pkg::sew_e     sew;
        logic [`VALU_XLEN-1:0]  vs1;
        logic [`VALU_XLEN-1:0]  vs2;
    } valu_op_t;

    typedef struct packed {
        logic [`VALU_XLEN-1:0]  data;
        logic                   illegal;    // data forced to zero
    } valu_res_t;

endpackage

`default_nettype wire

//--- logic/valu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_decode (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    input  valu_data_pkg::valu_req_t req,
    output logic                     op_valid,
    output valu_data_pkg::valu_op_t  op
);

    valu_isa_pkg::op_kind_e kind;
    logic                   sew_bad;

    assign sew_bad = req.sew > 3'(`VALU_SEW_MAX);

    always_comb begin
        kind = valu_isa_pkg::OPK_ILLEGAL;
        if (req.is_mask) begin
            // mask ops ignore sew
            case (req.opcode)
                valu_isa_pkg::OP_VMAND:    kind = valu_isa_pkg::OPK_MAND;
                valu_isa_pkg::OP_VMNAND:   kind = valu_isa_pkg::OPK_MNAND;
                valu_isa_pkg::OP_VMANDN:   kind = valu_isa_pkg::OPK_MANDN;
                valu_isa_pkg::OP_VMXOR:    kind = valu_isa_pkg::OPK_MXOR;
                valu_isa_pkg::OP_VMOR:     kind = valu_isa_pkg::OPK_MOR;
                valu_isa_pkg::OP_VMNOR:    kind = valu_isa_pkg::OPK_MNOR;
                valu_isa_pkg::OP_VMORN:    kind = valu_isa_pkg::OPK_MORN;
                valu_isa_pkg::OP_VMXNOR:   kind = valu_isa_pkg::OPK_MXNOR;
                valu_isa_pkg::OP_VMUNARY0: begin
                    if (req.vs1_index == valu_isa_pkg::VS1_VCPOP)
                        kind = valu_isa_pkg::OPK_CPOP;   // other selectors not kept
                end
                default:                   kind = valu_isa_pkg::OPK_ILLEGAL;
            endcase
        end else if (!sew_bad) begin
            case (req.opcode)
                valu_isa_pkg::OP_VAND:  kind = valu_isa_pkg::OPK_AND;
                valu_isa_pkg::OP_VOR:   kind = valu_isa_pkg::OPK_OR;
                valu_isa_pkg::OP_VXOR:  kind = valu_isa_pkg::OPK_XOR;
                valu_isa_pkg::OP_VADD:  kind = valu_isa_pkg::OPK_ADD;
                valu_isa_pkg::OP_VSUB:  kind = valu_isa_pkg::OPK_SUB;
                valu_isa_pkg::OP_VRSUB: kind = valu_isa_pkg::OPK_RSUB;
                valu_isa_pkg::OP_VMINU: kind = valu_isa_pkg::OPK_MINU;
                valu_isa_pkg::OP_VMIN:  kind = valu_isa_pkg::OPK_MIN;
                valu_isa_pkg::OP_VMAXU: kind = valu_isa_pkg::OPK_MAXU;
                valu_isa_pkg::OP_VMAX:  kind = valu_isa_pkg::OPK_MAX;
                default:                kind = valu_isa_pkg::OPK_ILLEGAL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            op_valid <= 1'b0;
        else
            op_valid <= in_valid;
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            op.kind <= kind;
            op.sew  <= req.sew;
            op.vs1  <= req.vs1;
            op.vs2  <= req.vs2;
        end
    end

    // strobe must stay clean for the writeback stage
    a_op_valid_known: assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(op_valid))
        else $error("op_valid unknown out of reset");

endmodule

`default_nettype wire

//--- logic/valu_int_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_int_unit (
    input  valu_data_pkg::valu_op_t op,
    output logic [`VALU_XLEN-1:0]   int_data
);

    localparam int XLEN = `VALU_XLEN;

    logic [XLEN-1:0] sew_mask;
    logic [XLEN-1:0] sign_bit;
    logic [XLEN-1:0] a;            // vs2 cut to sew
    logic [XLEN-1:0] b;            // vs1 cut to sew
    logic [XLEN-1:0] a_cmp;
    logic [XLEN-1:0] b_cmp;
    logic            is_signed;
    logic            lt;
    logic [XLEN-1:0] raw;

    always_comb begin
        case (op.sew)
            valu_isa_pkg::SEW_8:  sew_mask = {{(XLEN-8){1'b0}}, {8{1'b1}}};
            valu_isa_pkg::SEW_16: sew_mask = {{(XLEN-16){1'b0}}, {16{1'b1}}};
            valu_isa_pkg::SEW_32: sew_mask = {{(XLEN-32){1'b0}}, {32{1'b1}}};
            valu_isa_pkg::SEW_64: sew_mask = {XLEN{1'b1}};
            default:              sew_mask = '0;
        endcase
    end

    assign sign_bit = sew_mask ^ (sew_mask >> 1);   // top bit of the element
    assign a = op.vs2 & sew_mask;
    assign b = op.vs1 & sew_mask;

    assign is_signed = (op.kind == valu_isa_pkg::OPK_MIN) ||
                       (op.kind == valu_isa_pkg::OPK_MAX);

    // flipping the sign bit turns a signed compare into an unsigned one
    assign a_cmp = is_signed ? (a ^ sign_bit) : a;
    assign b_cmp = is_signed ? (b ^ sign_bit) : b;
    assign lt    = a_cmp < b_cmp;   // vs2 below vs1

    always_comb begin
        case (op.kind)
            valu_isa_pkg::OPK_AND:  raw = op.vs2 & op.vs1;
            valu_isa_pkg::OPK_OR:   raw = op.vs2 | op.vs1;
            valu_isa_pkg::OPK_XOR:  raw = op.vs2 ^ op.vs1;
            valu_isa_pkg::OPK_ADD:  raw = op.vs2 + op.vs1;
            valu_isa_pkg::OPK_SUB:  raw = op.vs2 - op.vs1;
            valu_isa_pkg::OPK_RSUB: raw = op.vs1 - op.vs2;
            valu_isa_pkg::OPK_MINU,
            valu_isa_pkg::OPK_MIN:  raw = lt ? a : b;
            valu_isa_pkg::OPK_MAXU,
            valu_isa_pkg::OPK_MAX:  raw = lt ? b : a;
            default:                raw = '0;
        endcase
    end

    assign int_data = raw & sew_mask;   // upper bits cleared

    // checked after the cycle settles, the shift is 64 for sew 64
    always_comb begin
        if (op.sew <= valu_isa_pkg::SEW_64) begin
            a_upper_zero: assert final ((int_data >> (8 << op.sew)) == '0)
                else $error("int result has bits above sew code %0d", op.sew);
        end
    end

endmodule

`default_nettype wire

//--- logic/valu_mask_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_mask_unit (
    input  valu_data_pkg::valu_op_t op,
    output logic [`VALU_XLEN-1:0]   mask_data
);

    localparam int XLEN = `VALU_XLEN;
    localparam int CNT_W = $clog2(XLEN + 1);

    // set-bit count of every byte value, 4 bits per entry
    function automatic logic [1023:0] build_pop_table();
        logic [1023:0] t;
        logic [3:0]    n;
        t = '0;
        for (int v = 0; v < 256; v++) begin
            n = '0;
            for (int i = 0; i < 8; i++)
                n = n + 4'(v[i]);
            t[v*4 +: 4] = n;
        end
        return t;
    endfunction

    localparam logic [1023:0] POP_TABLE = build_pop_table();

    logic [CNT_W-1:0] cpop_count;

    always_comb begin
        cpop_count = '0;
        for (int i = 0; i < `VALU_BYTES; i++)
            cpop_count = cpop_count + CNT_W'(POP_TABLE[{op.vs2[8*i +: 8], 2'b00} +: 4]);
    end

    always_comb begin
        case (op.kind)
            valu_isa_pkg::OPK_MAND:  mask_data = op.vs2 & op.vs1;
            valu_isa_pkg::OPK_MNAND: mask_data = ~(op.vs2 & op.vs1);
            valu_isa_pkg::OPK_MANDN: mask_data = op.vs2 & ~op.vs1;
            valu_isa_pkg::OPK_MXOR:  mask_data = op.vs2 ^ op.vs1;
            valu_isa_pkg::OPK_MOR:   mask_data = op.vs2 | op.vs1;
            valu_isa_pkg::OPK_MNOR:  mask_data = ~(op.vs2 | op.vs1);
            valu_isa_pkg::OPK_MORN:  mask_data = op.vs2 | ~op.vs1;
            valu_isa_pkg::OPK_MXNOR: mask_data = ~(op.vs2 ^ op.vs1);
            valu_isa_pkg::OPK_CPOP:  mask_data = {{(XLEN-CNT_W){1'b0}}, cpop_count};
            default:                 mask_data = '0;
        endcase
    end

    // a table slip would show up as an overflow of the byte sum
    always_comb begin
        if (op.kind == valu_isa_pkg::OPK_CPOP) begin
            a_cpop_range: assert final (mask_data <= XLEN)
                else $error("vcpop result %0d above word width", mask_data);
        end
    end

endmodule

`default_nettype wire

//--- logic/valu_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_writeback (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     op_valid,
    input  valu_data_pkg::valu_op_t  op,
    input  logic [`VALU_XLEN-1:0]    int_data,
    input  logic [`VALU_XLEN-1:0]    mask_data,
    output logic                     out_valid,
    output valu_data_pkg::valu_res_t res
);

    valu_data_pkg::valu_res_t sel;

    always_comb begin
        sel.illegal = 1'b0;
        if (op.kind == valu_isa_pkg::OPK_ILLEGAL) begin
            sel.data    = '0;
            sel.illegal = 1'b1;
        end else if (op.kind inside {[valu_isa_pkg::OPK_MAND:valu_isa_pkg::OPK_CPOP]}) begin
            sel.data = mask_data;
        end else begin
            sel.data = int_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            res       <= '0;
        end else begin
            out_valid <= op_valid;
            if (op_valid)
                res <= sel;   // holds last result between strobes
        end
    end

    // every op leaves next cycle with a settled result
    a_wb_latency: assert property (@(posedge clk) disable iff (!resetn)
        op_valid |=> out_valid && !$isunknown(res))
        else $error("op not followed by a known result one cycle later");

endmodule

`default_nettype wire

//--- logic/valu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module valu_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     in_valid,
    input  valu_data_pkg::valu_req_t req,
    output logic                     out_valid,
    output valu_data_pkg::valu_res_t res
);

    logic                    op_valid;
    valu_data_pkg::valu_op_t op;
    logic [`VALU_XLEN-1:0]   int_data;
    logic [`VALU_XLEN-1:0]   mask_data;

    valu_decode u_decode (
        .clk      (clk),
        .resetn   (resetn),
        .in_valid (in_valid),
        .req      (req),
        .op_valid (op_valid),
        .op       (op)
    );

    valu_int_unit u_int (
        .op       (op),
        .int_data (int_data)
    );

    valu_mask_unit u_mask (
        .op        (op),
        .mask_data (mask_data)
    );

    valu_writeback u_wb (
        .clk       (clk),
        .resetn    (resetn),
        .op_valid  (op_valid),
        .op        (op),
        .int_data  (int_data),
        .mask_data (mask_data),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- bench/valu_model.svh
`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

`include "valu_config.svh"

// one bit at a time, no table
function automatic int unsigned count_ones(logic [`VALU_XLEN-1:0] word);
    int unsigned n;
    n = 0;
    for (int i = 0; i < `VALU_XLEN; i++)
        n += word[i];
    return n;
endfunction

// low w bits of x read as a two's complement number
function automatic logic signed [`VALU_XLEN-1:0] as_signed(logic [`VALU_XLEN-1:0] x,
                                                           int unsigned w);
    logic signed [`VALU_XLEN-1:0] t;
    t = x << (`VALU_XLEN - w);
    return t >>> (`VALU_XLEN - w);
endfunction

function automatic valu_data_pkg::valu_res_t expected_result(valu_data_pkg::valu_req_t r);
    valu_data_pkg::valu_res_t e;
    logic [`VALU_XLEN-1:0]    keep;
    logic [`VALU_XLEN-1:0]    x;
    logic [`VALU_XLEN-1:0]    y;
    logic [`VALU_XLEN-1:0]    d;
    logic                     ok;
    int unsigned              w;
    ok = 1'b1;
    d = '0;
    w = 8 << r.sew;
    keep = (w >= `VALU_XLEN) ? '1 : ((`VALU_XLEN'(1) << w) - 1);
    x = r.vs2 & keep;
    y = r.vs1 & keep;
    if (r.is_mask) begin
        // full word, sew plays no part
        case (r.opcode)
            valu_isa_pkg::OP_VMAND:  d = r.vs2 & r.vs1;
            valu_isa_pkg::OP_VMNAND: d = ~(r.vs2 & r.vs1);
            valu_isa_pkg::OP_VMANDN: d = r.vs2 & ~r.vs1;
            valu_isa_pkg::OP_VMXOR:  d = r.vs2 ^ r.vs1;
            valu_isa_pkg::OP_VMOR:   d = r.vs2 | r.vs1;
            valu_isa_pkg::OP_VMNOR:  d = ~(r.vs2 | r.vs1);
            valu_isa_pkg::OP_VMORN:  d = r.vs2 | ~r.vs1;
            valu_isa_pkg::OP_VMXNOR: d = ~(r.vs2 ^ r.vs1);
            valu_isa_pkg::OP_VMUNARY0: begin
                if (r.vs1_index == valu_isa_pkg::VS1_VCPOP)
                    d = `VALU_XLEN'(count_ones(r.vs2));
                else
                    ok = 1'b0;
            end
            default: ok = 1'b0;
        endcase
    end else if (r.sew > `VALU_SEW_MAX) begin
        ok = 1'b0;
    end else begin
        case (r.opcode)
            valu_isa_pkg::OP_VAND:  d = x & y;
            valu_isa_pkg::OP_VOR:   d = x | y;
            valu_isa_pkg::OP_VXOR:  d = x ^ y;
            valu_isa_pkg::OP_VADD:  d = x + y;
            valu_isa_pkg::OP_VSUB:  d = x - y;
            valu_isa_pkg::OP_VRSUB: d = y - x;
            valu_isa_pkg::OP_VMINU: d = (x < y) ? x : y;
            valu_isa_pkg::OP_VMAXU: d = (x < y) ? y : x;
            valu_isa_pkg::OP_VMIN:  d = (as_signed(x, w) < as_signed(y, w)) ? x : y;
            valu_isa_pkg::OP_VMAX:  d = (as_signed(x, w) < as_signed(y, w)) ? y : x;
            default:                ok = 1'b0;
        endcase
        d = d & keep;   // nothing above sew
    end
    e.data = ok ? d : '0;
    e.illegal = ~ok;
    return e;
endfunction

`endif

//--- bench/tb_valu.sv
`timescale 1ns/1ps
`default_nettype none

`include "valu_config.svh"

module tb_valu;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_REQ      = 2000;
    localparam int LATENCY      = 2;
    // two cycles per request at worst, plus reset and drain
    localparam int LIMIT_NS     = NUM_REQ * 40 + RESET_CYCLES * CLK_PERIOD + 2000;

    typedef struct packed {
        valu_data_pkg::valu_res_t exp;
        int                       id;
        int                       cycle;   // edge that sampled in_valid
    } pend_t;

    logic                     clk = 1'b0;
    logic                     resetn;
    logic                     in_valid;
    valu_data_pkg::valu_req_t req;
    logic                     out_valid;
    valu_data_pkg::valu_res_t res;

    pend_t pending[$];
    pend_t ent;
    int    cycle = 0;
    int    next_id = 0;
    int    data_errors = 0;
    int    flag_errors = 0;
    int    order_errors = 0;
    int    proto_errors = 0;

    `include "valu_model.svh"

    valu_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .res       (res)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_data(input logic [`VALU_XLEN-1:0] got,
                              input logic [`VALU_XLEN-1:0] exp, input int id);
        if (got !== exp) begin
            data_errors++;
            $display("FAILED @%0t: request %0d data %h, expected %h", $time, id, got, exp);
        end
    endtask

    task automatic check_illegal(input logic got, input logic exp, input int id);
        if (got !== exp) begin
            flag_errors++;
            $display("FAILED @%0t: request %0d illegal %b, expected %b", $time, id, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int id);
        if (got != LATENCY) begin
            order_errors++;
            $display("FAILED @%0t: request %0d came back after %0d cycles, expected %0d",
                     $time, id, got, LATENCY);
        end
    endtask

    task automatic make_request(output valu_data_pkg::valu_req_t r);
        logic [5:0]  arith [10];
        logic [5:0]  mlogic [8];
        int unsigned pick;
        int unsigned w;
        // min and max first, picked by index below
        arith = '{valu_isa_pkg::OP_VMINU, valu_isa_pkg::OP_VMIN, valu_isa_pkg::OP_VMAXU,
                  valu_isa_pkg::OP_VMAX, valu_isa_pkg::OP_VAND, valu_isa_pkg::OP_VOR,
                  valu_isa_pkg::OP_VXOR, valu_isa_pkg::OP_VADD, valu_isa_pkg::OP_VSUB,
                  valu_isa_pkg::OP_VRSUB};
        mlogic = '{valu_isa_pkg::OP_VMAND, valu_isa_pkg::OP_VMNAND, valu_isa_pkg::OP_VMANDN,
                   valu_isa_pkg::OP_VMXOR, valu_isa_pkg::OP_VMOR, valu_isa_pkg::OP_VMNOR,
                   valu_isa_pkg::OP_VMORN, valu_isa_pkg::OP_VMXNOR};
        pick = $urandom_range(99);
        r.vs1 = {$urandom, $urandom};
        r.vs2 = {$urandom, $urandom};
        r.vs1_index = 5'($urandom);
        r.is_mask = 1'b0;
        r.sew = valu_isa_pkg::sew_e'(3'($urandom_range(3)));
        r.opcode = arith[$urandom_range(9)];
        if (pick < 10) begin
            // operands differ only in the element sign bit
            r.opcode = arith[$urandom_range(3)];
            w = 8 << r.sew;
            r.vs1 = r.vs2 ^ (`VALU_XLEN'(1) << (w - 1));
        end else if (pick < 50) begin
            r.is_mask = 1'b0;   // plain arithmetic as set up
        end else if (pick < 70) begin
            r.is_mask = 1'b1;
            r.opcode = mlogic[$urandom_range(7)];
            r.sew = valu_isa_pkg::sew_e'(3'($urandom_range(7)));
        end else if (pick < 82) begin
            r.is_mask = 1'b1;
            r.opcode = valu_isa_pkg::OP_VMUNARY0;
            r.vs1_index = valu_isa_pkg::VS1_VCPOP;
            case ($urandom_range(3))
                0:       r.vs2 = '0;
                1:       r.vs2 = '1;
                default: r.vs2 = {$urandom, $urandom};
            endcase
        end else if (pick < 88) begin
            r.sew = valu_isa_pkg::sew_e'(3'(4 + $urandom_range(3)));   // sew too wide
        end else if (pick < 94) begin
            r.is_mask = 1'b1;
            r.opcode = valu_isa_pkg::OP_VMUNARY0;
            r.vs1_index = valu_isa_pkg::VS1_VCPOP ^ 5'(1 + $urandom_range(30));
        end else begin
            r.is_mask = 1'($urandom);
            r.opcode = 6'($urandom);
            r.sew = valu_isa_pkg::sew_e'(3'($urandom_range(7)));
        end
    endtask

    // scoreboard; reads values from before the edge
    always @(posedge clk) begin
        cycle++;
        if (resetn !== 1'b1 && out_valid === 1'b1) begin
            proto_errors++;
            $display("ERROR @%0t: out_valid high while reset is asserted", $time);
        end
        if (out_valid === 1'b1) begin
            if (pending.size() == 0) begin
                proto_errors++;
                $display("ERROR @%0t: out_valid with no request outstanding", $time);
            end else begin
                ent = pending.pop_front();
                check_latency(cycle - ent.cycle, ent.id);
                check_data(res.data, ent.exp.data, ent.id);
                check_illegal(res.illegal, ent.exp.illegal, ent.id);
            end
        end
        if (resetn === 1'b1 && in_valid === 1'b1) begin
            ent.exp = expected_result(req);
            ent.id = next_id;
            ent.cycle = cycle;
            pending.push_back(ent);
            next_id++;
        end
    end

    initial begin
        valu_data_pkg::valu_req_t r;
        void'($urandom(32'ha747_6294));
        resetn = 1'b0;
        in_valid = 1'b0;
        req = '0;
        repeat (RESET_CYCLES - 1) begin
            @(posedge clk);
            in_valid <= 1'($urandom);   // strobes that reset must swallow
        end
        @(posedge clk);
        in_valid <= 1'b0;
        resetn <= 1'b1;
        @(posedge clk);
        check_data(res.data, '0, -1);   // res cleared by reset
        check_illegal(res.illegal, 1'b0, -1);
        for (int n = 0; n < NUM_REQ; n++) begin
            make_request(r);
            in_valid <= 1'b1;
            req <= r;
            @(posedge clk);
            if ($urandom_range(2) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
        while (pending.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);   // nothing stray after drain
        $display("requests %0d, errors: data %0d, illegal flag %0d, latency %0d, protocol %0d",
                 next_id, data_errors, flag_errors, order_errors, proto_errors);
        if (data_errors + flag_errors + order_errors + proto_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("ERROR @%0t: watchdog expired with %0d results still outstanding",
                 $time, pending.size());
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
+incdir+bench
logic/valu_isa_pkg.sv
logic/valu_data_pkg.sv
logic/valu_decode.sv
logic/valu_int_unit.sv
logic/valu_mask_unit.sv
logic/valu_writeback.sv
logic/valu_top.sv
bench/tb_valu.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_valu -f sources.f -o tb_valu || exit 1
out=$(./obj_dir/tb_valu)
echo "$out"
echo "$out" | grep -qx "Test OK" && exit 0 || exit 1
